/* verilog/game_pkg.sv */
package game_pkg;

	// Signed screen coordinate, one unit per pixel
	typedef logic signed [15:0] coord_t;

	// One bus word read either raw or as an x/y pair
	typedef union packed {
		logic [31:0] raw;	// Word as it crosses the bus
		struct packed {
			coord_t x;	// Upper half
			coord_t y;	// Lower half
		} xy;
	} pos_word_t;

	// Button field per player as wired on the GPIO header
	localparam int BTN_W = 10;	// Also the width of each output field
	localparam int BTN_LEFT = 0;
	localparam int BTN_RIGHT = 1;
	localparam int BTN_JUMP = 2;

	// Contact word bits from the collision test
	localparam int COLL_BOTTOM = 0;	// Standing on the stage
	localparam int COLL_TOP = 1;	// Bumped from below
	localparam int COLL_LEFT = 2;	// Hitting the left wall of the stage
	localparam int COLL_RIGHT = 3;	// Hitting the right wall

endpackage

/* verilog/mmio_map_pkg.sv */
package mmio_map_pkg;

	localparam int ADDR_W = 13;	// Byte address from the processor

	// Address fields
	localparam int REGION_BIT = 12;	// 0 RAM, 1 coprocessors
	localparam int BLK_MSB = 11;
	localparam int BLK_LSB = 7;
	localparam int REG_MSB = 6;
	localparam int REG_LSB = 2;	// Word aligned registers
	localparam int BLK_W = BLK_MSB - BLK_LSB + 1;
	localparam int REG_W = REG_MSB - REG_LSB + 1;

	// Block numbers in the coprocessor region
	localparam logic [BLK_W-1:0] BLK_PHYS1 = 5'd0;
	localparam logic [BLK_W-1:0] BLK_PHYS2 = 5'd1;
	localparam logic [BLK_W-1:0] BLK_CTRL1 = 5'd4;
	localparam logic [BLK_W-1:0] BLK_CTRL2 = 5'd5;
	localparam logic [BLK_W-1:0] BLK_VGA1 = 5'd8;
	localparam logic [BLK_W-1:0] BLK_VGA2 = 5'd9;
	localparam logic [BLK_W-1:0] BLK_VGA_STAGE = 5'd10;
	localparam logic [BLK_W-1:0] BLK_COLL = 5'd12;

	// Registers inside a physics block
	localparam logic [REG_W-1:0] REG_GRAV = 5'd0;
	localparam logic [REG_W-1:0] REG_WIND = 5'd1;
	localparam logic [REG_W-1:0] REG_START = 5'd2;	// Strobe with word
	localparam logic [REG_W-1:0] REG_KNOCK = 5'd3;	// Strobe with word
	localparam logic [REG_W-1:0] REG_STEP = 5'd4;	// Strobe only

	// Registers inside a VGA block
	localparam logic [REG_W-1:0] REG_POS = 5'd0;
	localparam logic [REG_W-1:0] REG_WH = 5'd1;

endpackage

/* verilog/dmem.sv */
module dmem #(
	parameter int DMEM_AW = 12	// Word address width
) (
	input logic clock,
	input logic [DMEM_AW-1:0] address,
	input logic [31:0] data,
	input logic wren,
	output logic [31:0] q
);

	logic [31:0] mem [2**DMEM_AW];	// Data storage

	// Read sees the old word when the same address is written
	always_ff @(posedge clock) begin
		if (wren) begin
			mem[address] <= data;
		end
		q <= mem[address];	// Registered read, one cycle
	end

	// The hub must present a clean address with every RAM write strobe
	a_wr_addr_known: assert property (
		@(posedge clock) wren |-> !$isunknown(address)
	) else $error("dmem write with unknown address %h", address);

endmodule

/* verilog/physics_coprocessor.sv */
module physics_coprocessor import game_pkg::*; #(
	parameter int MOVE_SPEED = 4,	// Horizontal speed while held
	parameter int JUMP_SPEED = 12,	// Launch speed off the stage
	parameter int MAX_FALL = 16	// Terminal downward speed
) (
	input logic clock,
	input logic reset,
	input coord_t gravity,	// Added to vy every step
	input coord_t wind,	// Added to vx every step
	input logic start_load,	// Place the player
	input pos_word_t start_pos,
	input logic knock_load,	// Queue a knockback
	input pos_word_t knock,
	input logic [BTN_W-1:0] buttons,	// Synchronized controller bits
	input logic [3:0] contact,	// From the collision unit
	input logic step,	// Advance one frame
	output pos_word_t position
);

	localparam coord_t MOVE_C = coord_t'(MOVE_SPEED);
	localparam coord_t JUMP_C = coord_t'(JUMP_SPEED);
	localparam coord_t FALL_C = coord_t'(MAX_FALL);

	coord_t vy;	// Vertical speed, carried between steps
	coord_t knock_vx;	// Knockback waiting for the next step
	coord_t knock_vy;
	coord_t vx;	// Horizontal speed, rebuilt every step
	coord_t vy_next;

	// Horizontal motion has no memory beyond the queued knock
	always_comb begin
		vx = knock_vx + wind;
		if (buttons[BTN_RIGHT]) begin
			vx = vx + MOVE_C;
		end
		if (buttons[BTN_LEFT]) begin
			vx = vx - MOVE_C;	// Both held cancels out
		end
	end

	// Vertical motion integrates gravity
	always_comb begin
		vy_next = vy + gravity + knock_vy;
		if (contact[COLL_BOTTOM] && vy_next > 0) begin	// Landing
			if (buttons[BTN_JUMP]) begin
				vy_next = -JUMP_C;	// Jump only from the ground
			end else begin
				vy_next = '0;
			end
		end
		if (vy_next > FALL_C) begin
			vy_next = FALL_C;	// Terminal speed
		end
	end

	// Only one of the three strobes arrives in any cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			position.raw <= '0;
			vy <= '0;
			knock_vx <= '0;
			knock_vy <= '0;
		end else if (start_load) begin
			position <= start_pos;	// Fresh spawn, at rest
			vy <= '0;
			knock_vx <= '0;
			knock_vy <= '0;
		end else if (knock_load) begin
			knock_vx <= knock_vx + knock.xy.x;	// Hits stack up
			knock_vy <= knock_vy + knock.xy.y;
		end else if (step) begin
			vy <= vy_next;
			position.xy.x <= position.xy.x + vx;	// Wraps at 16 bits
			position.xy.y <= position.xy.y + vy_next;
			knock_vx <= '0;	// Knock is spent
			knock_vy <= '0;
		end
	end

	// Vertical move of one step stays within terminal speed
	a_max_fall: assert property (
		@(posedge clock) disable iff (reset)
		step && !start_load && !knock_load
			|=> coord_t'(position.xy.y - $past(position.xy.y)) <= FALL_C
	) else $error("vy %0d above MAX_FALL", vy);

endmodule

/* verilog/collision.sv */
module collision import game_pkg::*; (
	input pos_word_t player_pos,	// Top left corner
	input pos_word_t player_size,	// Width and height
	input pos_word_t stage_pos,
	input pos_word_t stage_size,
	output logic [3:0] contact
);

	// One spare bit so edges far out do not wrap
	logic signed [16:0] px0, px1, py0, py1;
	logic signed [16:0] sx0, sx1, sy0, sy1;
	logic over_x, over_y, hit;

	assign px0 = player_pos.xy.x;
	assign py0 = player_pos.xy.y;
	assign px1 = px0 + 17'(player_size.xy.x);	// Right edge, inclusive
	assign py1 = py0 + 17'(player_size.xy.y);	// Bottom edge, inclusive

	assign sx0 = stage_pos.xy.x;
	assign sy0 = stage_pos.xy.y;
	assign sx1 = sx0 + 17'(stage_size.xy.x);
	assign sy1 = sy0 + 17'(stage_size.xy.y);

	// Overlap unless one span ends before the other starts
	assign over_x = !(px1 < sx0 || sx1 < px0);
	assign over_y = !(py1 < sy0 || sy1 < py0);
	assign hit = over_x && over_y;

	assign contact[COLL_BOTTOM] = hit && (py0 < sy0);	// Player above stage top
	assign contact[COLL_TOP] = hit && (py1 > sy1);	// Below stage bottom
	assign contact[COLL_LEFT] = hit && (px0 < sx0);
	assign contact[COLL_RIGHT] = hit && (px1 > sx1);

endmodule

/* verilog/controller_manager.sv */
module controller_manager import game_pkg::*; (
	input logic clock,
	input logic reset,
	input logic [BTN_W-1:0] pins_in,	// Raw buttons from the header
	input logic out_load,	// Bus write to this block
	input logic [BTN_W-1:0] out_data,
	output logic [BTN_W-1:0] pins_out,	// LEDs and rumble pins
	output logic [BTN_W-1:0] buttons	// Safe to use in the core clock
);

	logic [BTN_W-1:0] pins_meta;	// First sync stage

	// Two flops against metastability
	always_ff @(posedge clock) begin
		if (reset) begin
			pins_meta <= '0;
			buttons <= '0;
		end else begin
			pins_meta <= pins_in;
			buttons <= pins_meta;
		end
	end

	// Output latch, holds until the next write
	always_ff @(posedge clock) begin
		if (reset) begin
			pins_out <= '0;
		end else if (out_load) begin
			pins_out <= out_data;
		end
	end

endmodule

/* verilog/mmio.sv */
module mmio import game_pkg::*, mmio_map_pkg::*; #(
	parameter int DMEM_AW = 12,	// RAM word address width
	parameter int MOVE_SPEED = 4,
	parameter int JUMP_SPEED = 12,
	parameter int MAX_FALL = 16
) (
	input logic clock,
	input logic reset,
	input logic [ADDR_W-1:0] address,
	input logic [31:0] data_in,
	input logic wren,
	output logic [31:0] data_out,	// Word for last cycle's address
	input logic [2*BTN_W-1:0] gpio_in,	// Player 1 low, player 2 high
	output logic [2*BTN_W-1:0] gpio_out,
	output logic [63:0] p1_vga,	// Position then size
	output logic [63:0] p2_vga,
	output logic [63:0] stage_vga
);

	logic region;	// High for coprocessor space
	logic [BLK_W-1:0] blk;
	logic [REG_W-1:0] rsel;
	logic co_wr;
	logic [1:0] phys_hit, ctrl_hit;
	logic [2:0] vga_hit;	// P1, P2, stage

	assign region = address[REGION_BIT];
	assign blk = address[BLK_MSB:BLK_LSB];
	assign rsel = address[REG_MSB:REG_LSB];
	assign co_wr = wren && region;

	assign phys_hit = {co_wr && (blk == BLK_PHYS2), co_wr && (blk == BLK_PHYS1)};
	assign ctrl_hit = {co_wr && (blk == BLK_CTRL2), co_wr && (blk == BLK_CTRL1)};
	assign vga_hit = {co_wr && (blk == BLK_VGA_STAGE), co_wr && (blk == BLK_VGA2),
		co_wr && (blk == BLK_VGA1)};

	coord_t gravity [2];
	coord_t wind [2];
	pos_word_t vga_pos [3];	// Index 2 is the stage
	pos_word_t vga_wh [3];
	pos_word_t wr_word_q;	// Word that rides with start and knock strobes
	logic [1:0] step_q, start_q, knock_q;	// One cycle strobes per player

	// Register file and command strobes
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int p = 0; p < 2; p++) begin
				gravity[p] <= '0;
				wind[p] <= '0;
			end
			for (int v = 0; v < 3; v++) begin
				vga_pos[v].raw <= '0;
				vga_wh[v].raw <= '0;
			end
			step_q <= '0;
			start_q <= '0;
			knock_q <= '0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (phys_hit[p] && rsel == REG_GRAV) begin
					gravity[p] <= coord_t'(data_in[15:0]);	// Low half only
				end
				if (phys_hit[p] && rsel == REG_WIND) begin
					wind[p] <= coord_t'(data_in[15:0]);
				end
				step_q[p] <= phys_hit[p] && (rsel == REG_STEP);	// Data ignored
				start_q[p] <= phys_hit[p] && (rsel == REG_START);
				knock_q[p] <= phys_hit[p] && (rsel == REG_KNOCK);
			end
			for (int v = 0; v < 3; v++) begin
				if (vga_hit[v] && rsel == REG_POS) begin
					vga_pos[v].raw <= data_in;
				end
				if (vga_hit[v] && rsel == REG_WH) begin
					vga_wh[v].raw <= data_in;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (co_wr) begin
			wr_word_q.raw <= data_in;
		end
	end

	logic [31:0] ram_q;

	dmem #(.DMEM_AW(DMEM_AW)) u_dmem (
		.clock(clock),
		.address(address[DMEM_AW-1:0]),
		.data(data_in),
		.wren(wren && !region),	// Lower half only
		.q(ram_q)
	);

	pos_word_t position [2];
	logic [BTN_W-1:0] buttons [2];
	logic [3:0] contact [2];

	for (genvar p = 0; p < 2; p++) begin : g_player
		controller_manager u_ctrl (
			.clock(clock),
			.reset(reset),
			.pins_in(gpio_in[p*BTN_W +: BTN_W]),
			.out_load(ctrl_hit[p]),	// Any offset in the block
			.out_data(data_in[BTN_W-1:0]),
			.pins_out(gpio_out[p*BTN_W +: BTN_W]),
			.buttons(buttons[p])
		);

		// Sprite size doubles as the hit box
		collision u_coll (
			.player_pos(position[p]),
			.player_size(vga_wh[p]),
			.stage_pos(vga_pos[2]),
			.stage_size(vga_wh[2]),
			.contact(contact[p])
		);

		physics_coprocessor #(
			.MOVE_SPEED(MOVE_SPEED),
			.JUMP_SPEED(JUMP_SPEED),
			.MAX_FALL(MAX_FALL)
		) u_phys (
			.clock(clock),
			.reset(reset),
			.gravity(gravity[p]),
			.wind(wind[p]),
			.start_load(start_q[p]),
			.start_pos(wr_word_q),
			.knock_load(knock_q[p]),
			.knock(wr_word_q),
			.buttons(buttons[p]),
			.contact(contact[p]),
			.step(step_q[p]),
			.position(position[p])
		);
	end

	// Sprite words with players drawn at their physics position
	assign p1_vga = {position[0].raw, vga_wh[0].raw};
	assign p2_vga = {position[1].raw, vga_wh[1].raw};
	assign stage_vga = {vga_pos[2].raw, vga_wh[2].raw};

	function automatic logic [31:0] vga_read(input pos_word_t pos, input pos_word_t wh,
		input logic [REG_W-1:0] r);
		return (r == REG_POS) ? pos.raw : (r == REG_WH) ? wh.raw : 32'd0;
	endfunction

	logic [31:0] co_rd;	// Coprocessor readback, same cycle

	always_comb begin
		case (blk)
			BLK_PHYS1: co_rd = position[0].raw;
			BLK_PHYS2: co_rd = position[1].raw;
			BLK_CTRL1: co_rd = {{(32 - BTN_W){1'b0}}, buttons[0]};
			BLK_CTRL2: co_rd = {{(32 - BTN_W){1'b0}}, buttons[1]};
			BLK_VGA1: co_rd = vga_read(vga_pos[0], vga_wh[0], rsel);
			BLK_VGA2: co_rd = vga_read(vga_pos[1], vga_wh[1], rsel);
			BLK_VGA_STAGE: co_rd = vga_read(vga_pos[2], vga_wh[2], rsel);
			BLK_COLL: co_rd = {24'd0, contact[1], contact[0]};
			default: co_rd = '0;	// Unmapped blocks read zero
		endcase
	end

	logic region_q;	// Region of the address being answered
	logic [31:0] co_rd_q;

	// Reset parks the mux on the cleared readback so data_out starts at zero
	always_ff @(posedge clock) begin
		if (reset) begin
			region_q <= 1'b1;
			co_rd_q <= '0;
		end else begin
			region_q <= region;
			co_rd_q <= co_rd;
		end
	end

	assign data_out = region_q ? co_rd_q : ram_q;	// Both sides one cycle late

	// Processor never repeats a strobe register write on back to back cycles
	logic [5:0] pulses;

	assign pulses = {step_q, start_q, knock_q};

	a_pulse_single: assert property (
		@(posedge clock) disable iff (reset) (pulses & $past(pulses)) == '0
	) else $error("command strobe held two cycles %b", pulses);

endmodule

/* testbench/tb_clock.sv */
module tb_clock (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;	// Period 20
	end

	// Reset held over the first five rising edges
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

/* testbench/mmio_tb.sv */
module mmio_tb import game_pkg::*, mmio_map_pkg::*;;

	localparam int MOVE_SPEED = 4;	// DUT defaults
	localparam int JUMP_SPEED = 12;
	localparam int MAX_FALL = 16;
	localparam int TIMEOUT_CYCLES = 6000;	// Well above the length of the full run

	logic clock, reset;
	logic [ADDR_W-1:0] address;
	logic [31:0] data_in, data_out;
	logic wren;
	logic [2*BTN_W-1:0] gpio_in, gpio_out;
	logic [63:0] p1_vga, p2_vga, stage_vga;

	integer seed = 32'hc262;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// Reference state of both players and the sprite registers
	int mx [2], my [2], mvy [2], mkx [2], mky [2];
	int grav_m [2], wind_m [2];
	logic [BTN_W-1:0] btn_m [2];
	pos_word_t vpos_m [3], vwh_m [3];	// Index 2 is the stage

	tb_clock u_clk (.clock(clock), .reset(reset));

	mmio uut (
		.clock(clock), .reset(reset),
		.address(address), .data_in(data_in), .wren(wren), .data_out(data_out),
		.gpio_in(gpio_in), .gpio_out(gpio_out),
		.p1_vga(p1_vga), .p2_vga(p2_vga), .stage_vga(stage_vga)
	);

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_pos(input string name, input pos_word_t got, input pos_word_t exp);
		checks++;
		if (got.raw !== exp.raw) begin
			errors++;
			$display("Fail %s: got x=%h y=%h expected x=%h y=%h", name,
				got.xy.x, got.xy.y, exp.xy.x, exp.xy.y);
		end
	endtask

	task automatic check_contact(input string name, input logic [3:0] got, input logic [3:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_vga(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	function automatic logic [ADDR_W-1:0] co_addr(input logic [BLK_W-1:0] b,
		input logic [REG_W-1:0] r);
		logic [ADDR_W-1:0] a;
		a = '0;
		a[REGION_BIT] = 1'b1;
		a[BLK_MSB:BLK_LSB] = b;
		a[REG_MSB:REG_LSB] = r;
		return a;
	endfunction

	function automatic logic [BLK_W-1:0] vga_blk(input int v);
		return (v == 0) ? BLK_VGA1 : (v == 1) ? BLK_VGA2 : BLK_VGA_STAGE;
	endfunction

	function automatic int wrap16(input int v);
		coord_t t;
		t = coord_t'(v);	// Screen coordinates wrap at 16 bits
		return int'(t);
	endfunction

	function automatic pos_word_t pos_of(input int x, input int y);
		pos_word_t w;
		w.xy.x = coord_t'(x);
		w.xy.y = coord_t'(y);
		return w;
	endfunction

	function automatic logic [63:0] expected_vga(input int p);
		pos_word_t w;
		w = pos_of(mx[p], my[p]);
		return {w.raw, vwh_m[p].raw};
	endfunction

	// Contact bits from the rectangle rules with inclusive spans
	function automatic logic [3:0] model_contact(input int p);
		int px0, py0, px1, py1, sx0, sy0, sx1, sy1;
		logic hit;
		logic [3:0] c;
		px0 = mx[p];
		py0 = my[p];
		px1 = px0 + int'(vwh_m[p].xy.x);
		py1 = py0 + int'(vwh_m[p].xy.y);
		sx0 = int'(vpos_m[2].xy.x);
		sy0 = int'(vpos_m[2].xy.y);
		sx1 = sx0 + int'(vwh_m[2].xy.x);
		sy1 = sy0 + int'(vwh_m[2].xy.y);
		hit = (px1 >= sx0) && (sx1 >= px0) && (py1 >= sy0) && (sy1 >= py0);
		c = '0;
		c[COLL_BOTTOM] = hit && (py0 < sy0);
		c[COLL_TOP] = hit && (py1 > sy1);
		c[COLL_LEFT] = hit && (px0 < sx0);
		c[COLL_RIGHT] = hit && (px1 > sx1);
		return c;
	endfunction

	task automatic model_step(input int p);
		logic [3:0] c;
		int vx, vy;
		c = model_contact(p);	// Contact seen before the move
		vx = mkx[p] + wind_m[p];
		if (btn_m[p][BTN_RIGHT]) vx = vx + MOVE_SPEED;
		if (btn_m[p][BTN_LEFT]) vx = vx - MOVE_SPEED;
		vy = mvy[p] + grav_m[p] + mky[p];
		if (c[COLL_BOTTOM] && vy > 0) vy = btn_m[p][BTN_JUMP] ? -JUMP_SPEED : 0;
		if (vy > MAX_FALL) vy = MAX_FALL;
		mvy[p] = vy;
		mx[p] = wrap16(mx[p] + vx);
		my[p] = wrap16(my[p] + vy);
		mkx[p] = 0;	// Knock used up
		mky[p] = 0;
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [31:0] d);
		@(posedge clock);
		address <= a;
		data_in <= d;
		wren <= 1'b1;
		@(posedge clock);	// Write lands on this edge
		wren <= 1'b0;
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [31:0] d);
		@(posedge clock);
		address <= a;
		wren <= 1'b0;
		@(posedge clock);
		@(negedge clock);	// Word settled one cycle later
		d = data_out;
	endtask

	task automatic set_buttons(input logic [BTN_W-1:0] b1, input logic [BTN_W-1:0] b2);
		@(posedge clock);
		gpio_in <= {b2, b1};
		btn_m[0] = b1;
		btn_m[1] = b2;
		repeat (3) @(posedge clock);	// Through both sync flops
	endtask

	task automatic vga_write(input int v, input logic [REG_W-1:0] r, input logic [31:0] w);
		bus_write(co_addr(vga_blk(v), r), w);
		if (r == REG_POS) vpos_m[v].raw = w;
		else vwh_m[v].raw = w;
	endtask

	task automatic phys_write(input int p, input logic [REG_W-1:0] r, input logic [31:0] word);
		pos_word_t w;
		w.raw = word;
		bus_write(co_addr((p == 0) ? BLK_PHYS1 : BLK_PHYS2, r), word);
		case (r)
			REG_GRAV: grav_m[p] = int'(coord_t'(word[15:0]));
			REG_WIND: wind_m[p] = int'(coord_t'(word[15:0]));
			REG_START: begin
				mx[p] = int'(w.xy.x);
				my[p] = int'(w.xy.y);
				mvy[p] = 0;
				mkx[p] = 0;
				mky[p] = 0;
			end
			REG_KNOCK: begin
				mkx[p] = mkx[p] + int'(w.xy.x);	// Hits add up until the step
				mky[p] = mky[p] + int'(w.xy.y);
			end
			REG_STEP: model_step(p);
			default: ;
		endcase
	endtask

	task automatic step_and_check(input int p, output pos_word_t pos);
		logic [31:0] got;
		phys_write(p, REG_STEP, 32'd0);
		bus_read(co_addr((p == 0) ? BLK_PHYS1 : BLK_PHYS2, 5'd0), got);
		pos = pos_word_t'(got);
		check_pos((p == 0) ? "p1 position" : "p2 position", pos, pos_of(mx[p], my[p]));
		check_vga((p == 0) ? "p1_vga" : "p2_vga", (p == 0) ? p1_vga : p2_vga, expected_vga(p));
	endtask

	task automatic probe_stage_contact(input logic [31:0] spos, input logic [31:0] ssize);
		logic [31:0] got;
		vga_write(2, REG_POS, spos);
		vga_write(2, REG_WH, ssize);
		bus_read(co_addr(BLK_COLL, 5'd0), got);
		check_contact("p2 contact", got[7:4], model_contact(1));
		check_contact("p1 contact", got[3:0], model_contact(0));
	endtask

	task automatic test_ram();
		logic [11:0] addrs [32];
		logic [31:0] datas [32];
		logic [31:0] got;
		for (int i = 0; i < 32; i++) begin
			addrs[i] = {i[4:0], 7'($random(seed))};	// Distinct per index
			datas[i] = $random(seed);
			bus_write({1'b0, addrs[i]}, datas[i]);
		end
		for (int i = 0; i < 32; i++) begin
			bus_read({1'b0, addrs[i]}, got);
			check_word("ram data_out", got, datas[i]);
		end
	endtask

	task automatic test_ctrl();
		logic [19:0] pins;
		logic [31:0] got, w1, w2;
		repeat (2) begin
			pins = 20'($random(seed));
			set_buttons(pins[9:0], pins[19:10]);
			bus_read(co_addr(BLK_CTRL1, 5'd0), got);
			check_word("ctrl1 buttons", got, {22'd0, pins[9:0]});
			bus_read(co_addr(BLK_CTRL2, 5'd0), got);
			check_word("ctrl2 buttons", got, {22'd0, pins[19:10]});
		end
		w1 = $random(seed);
		w2 = $random(seed);
		bus_write(co_addr(BLK_CTRL1, 5'd0), w1);
		bus_write(co_addr(BLK_CTRL2, 5'd0), w2);
		@(negedge clock);
		check_word("gpio_out", {12'd0, gpio_out}, {12'd0, w2[9:0], w1[9:0]});
	endtask

	task automatic test_sprites();
		logic [31:0] got;
		for (int v = 0; v < 3; v++) begin
			vga_write(v, REG_POS, $random(seed));
			vga_write(v, REG_WH, $random(seed));
		end
		@(negedge clock);
		check_vga("stage_vga", stage_vga, {vpos_m[2].raw, vwh_m[2].raw});
		check_vga("p1_vga", p1_vga, expected_vga(0));	// Position half from physics
		check_vga("p2_vga", p2_vga, expected_vga(1));
		for (int v = 0; v < 3; v++) begin
			bus_read(co_addr(vga_blk(v), REG_POS), got);
			check_word("vga pos readback", got, vpos_m[v].raw);
			bus_read(co_addr(vga_blk(v), REG_WH), got);
			check_word("vga size readback", got, vwh_m[v].raw);
		end
	endtask

	task automatic test_free_fall();
		pos_word_t pos;
		logic [31:0] got;
		vga_write(2, REG_POS, {16'd20000, 16'd20000});	// Stage well out of reach
		vga_write(2, REG_WH, {16'd10, 16'd10});
		vga_write(0, REG_WH, {16'd16, 16'd16});
		set_buttons(10'b0000000010, 10'd0);	// Right held
		phys_write(0, REG_GRAV, 32'd3);
		phys_write(0, REG_WIND, 32'h0000_ffff);	// Wind of minus one
		phys_write(0, REG_START, {16'd100, 16'd50});
		bus_read(co_addr(BLK_PHYS1, 5'd0), got);
		check_pos("p1 start", pos_word_t'(got), pos_of(100, 50));
		for (int i = 0; i < 12; i++) begin
			if (i == 6) set_buttons(10'b0000000001, 10'd0);	// Switch to left
			step_and_check(0, pos);
		end
	endtask

	task automatic test_landing();
		pos_word_t pos;
		logic [31:0] got;
		logic [3:0] c;
		int n, y0;
		vga_write(1, REG_WH, {16'd8, 16'd8});
		vga_write(2, REG_POS, {16'd190, 16'd160});	// Floor under player 2
		vga_write(2, REG_WH, {16'd40, 16'd20});
		phys_write(1, REG_GRAV, 32'd2);
		phys_write(1, REG_START, {16'd200, 16'd100});
		n = 0;
		c = model_contact(1);
		while (!c[COLL_BOTTOM] && n < 20) begin
			step_and_check(1, pos);
			n++;
			c = model_contact(1);
		end
		if (!c[COLL_BOTTOM]) begin
			errors++;
			$display("Player 2 never reached the stage within 20 steps");
		end
		bus_read(co_addr(BLK_COLL, 5'd0), got);
		check_contact("p2 contact", got[7:4], model_contact(1));
		check_contact("p1 contact", got[3:0], model_contact(0));
		y0 = my[1];
		step_and_check(1, pos);
		check_word("p2 y after landing", {16'd0, pos.xy.y}, {16'd0, 16'(y0)});
		set_buttons(btn_m[0], 10'b0000000100);	// Jump held
		step_and_check(1, pos);
		check_word("p2 y after jump", {16'd0, pos.xy.y}, {16'd0, 16'(y0 - JUMP_SPEED)});
		// Stage moved around player 2 so every contact bit gets set
		probe_stage_contact({16'd202, 16'd146}, {16'd2, 16'd2});	// Inside the player
		probe_stage_contact({16'd204, 16'd140}, {16'd20, 16'd20});
		probe_stage_contact({16'd190, 16'd140}, {16'd14, 16'd20});
		probe_stage_contact({16'd190, 16'd130}, {16'd40, 16'd18});
	endtask

	task automatic test_knock();
		pos_word_t pos;
		int x1;
		phys_write(0, REG_KNOCK, {16'd7, 16'hfffb});
		step_and_check(0, pos);
		x1 = int'(pos.xy.x);
		step_and_check(0, pos);	// Knock must be gone here
		check_word("p1 x step after knock", 32'(int'(pos.xy.x) - x1), 32'(-1 - MOVE_SPEED));
	endtask

	initial begin
		address = '0;
		data_in = '0;
		wren = 1'b0;
		gpio_in = '0;
		for (int v = 0; v < 3; v++) begin
			vpos_m[v].raw = '0;
			vwh_m[v].raw = '0;
		end
		for (int p = 0; p < 2; p++) begin
			mx[p] = 0;
			my[p] = 0;
			mvy[p] = 0;
			mkx[p] = 0;
			mky[p] = 0;
			grav_m[p] = 0;
			wind_m[p] = 0;
			btn_m[p] = '0;
		end
		@(posedge clock);
		while (reset) @(posedge clock);
		test_ram();
		test_ctrl();
		test_sprites();
		test_free_fall();
		test_landing();
		test_knock();
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* all.f */
verilog/game_pkg.sv
verilog/mmio_map_pkg.sv
verilog/dmem.sv
verilog/physics_coprocessor.sv
verilog/collision.sv
verilog/controller_manager.sv
verilog/mmio.sv
testbench/tb_clock.sv
testbench/mmio_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mmio_tb -f all.f -o mmio_sim

./obj_dir/mmio_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
